//--- Bender.yml
package:
  name: fir_filter

sources:
  - files:
      - design/fir_pkg.sv
      - design/fir_mac_slice.sv
      - design/fir_symmetric_chain.sv
      - design/fir_wb_regs.sv
      - design/fir_round_sat.sv
      - design/fir_filter_top.sv
  - target: test
    files:
      - testbench/fir_filter_tb.sv

//--- design/fir_filter_top.sv
// Symmetric FIR filter top level
// Register slave, systolic MAC chain and rounding output stage
`timescale 1ns/1ns
`default_nettype none

module fir_filter_top #(
  parameter int IN_WIDTH    = $bits(fir_pkg::sample_t),
  parameter int COEFF_WIDTH = $bits(fir_pkg::coeff_t),
  parameter int ACCUM_WIDTH = $bits(fir_pkg::accum_t),
  parameter int OUT_WIDTH   = $bits(fir_pkg::out_t),
  parameter int NUM_SLICES  = 4,   // Tap pairs
  parameter int OUT_SHIFT   = 15
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         wb_cyc,
  input  wire                         wb_stb,
  input  wire                         wb_we,
  input  wire fir_pkg::wb_addr_t      wb_adr,
  input  wire fir_pkg::wb_data_t      wb_dat_w,
  input  wire                         sample_stb,
  input  wire signed [IN_WIDTH-1:0]   sample_in,
  output fir_pkg::wb_data_t           wb_dat_r,
  output logic                        wb_ack,
  output logic                        out_stb,
  output logic signed [OUT_WIDTH-1:0] out_data
);

  logic                          coeff_load;
  logic signed [COEFF_WIDTH-1:0] coeff_data;
  logic                          clear;       // To chain, output stage and counters
  logic                          sat;         // Back to the saturation counter
  logic signed [ACCUM_WIDTH-1:0] accum;       // Full precision chain result

  fir_wb_regs #(
    .COEFF_WIDTH(COEFF_WIDTH)
  ) wb_regs_i (
    .clk       (clk),
    .rst       (rst),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .sat       (sat),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .coeff_load(coeff_load),
    .coeff_data(coeff_data),
    .clear     (clear)
  );

  fir_symmetric_chain #(
    .IN_WIDTH   (IN_WIDTH),
    .COEFF_WIDTH(COEFF_WIDTH),
    .ACCUM_WIDTH(ACCUM_WIDTH),
    .NUM_SLICES (NUM_SLICES)
  ) chain_i (
    .clk       (clk),
    .rst       (rst),
    .clear     (clear),
    .sample_stb(sample_stb),
    .sample_in (sample_in),
    .coeff_load(coeff_load),
    .coeff_data(coeff_data),
    .accum_out (accum)
  );

  fir_round_sat #(
    .ACCUM_WIDTH(ACCUM_WIDTH),
    .OUT_WIDTH  (OUT_WIDTH),
    .OUT_SHIFT  (OUT_SHIFT)
  ) round_i (
    .clk       (clk),
    .rst       (rst),
    .clear     (clear),
    .sample_stb(sample_stb),
    .accum_in  (accum),
    .out_stb   (out_stb),
    .out_data  (out_data),
    .sat       (sat)
  );

endmodule

`default_nettype wire

//--- design/fir_mac_slice.sv
// One tap pair of the symmetric systolic FIR
// Pre-adder, multiplier and accumulate stage
// Forwards samples and coefficients to the next slice
`timescale 1ns/1ns
`default_nettype none

module fir_mac_slice #(
  parameter int IN_WIDTH    = $bits(fir_pkg::sample_t),
  parameter int COEFF_WIDTH = $bits(fir_pkg::coeff_t),
  parameter int ACCUM_WIDTH = $bits(fir_pkg::accum_t)
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           clear,       // Zero taps and pipeline
  input  wire                           sample_stb,  // Advances the data path
  input  wire signed [IN_WIDTH-1:0]     sample_a,    // Forward travelling sample
  input  wire signed [IN_WIDTH-1:0]     sample_b,    // Mirrored partner from fold-back
  input  wire signed [COEFF_WIDTH-1:0]  coeff_in,
  input  wire                           coeff_load,  // Independent of sample_stb
  input  wire signed [ACCUM_WIDTH-1:0]  accum_in,    // From previous slice
  output logic signed [IN_WIDTH-1:0]    sample_fwd,
  output logic signed [COEFF_WIDTH-1:0] coeff_fwd,
  output logic signed [ACCUM_WIDTH-1:0] accum_out
);

  localparam int SUM_WIDTH  = IN_WIDTH + 1;           // Pre-adder needs one growth bit
  localparam int PROD_WIDTH = SUM_WIDTH + COEFF_WIDTH;

  logic signed [IN_WIDTH-1:0]    a0_reg;     // a-path, two stages deep
  logic signed [IN_WIDTH-1:0]    a1_reg;
  logic signed [IN_WIDTH-1:0]    b_reg;      // b-path, one stage
  logic signed [SUM_WIDTH-1:0]   sum_reg;    // Pre-add result
  logic signed [COEFF_WIDTH-1:0] coeff_reg;  // Held tap
  logic signed [PROD_WIDTH-1:0]  prod_reg;
  logic signed [ACCUM_WIDTH-1:0] acc_reg;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      a0_reg    <= '0;
      a1_reg    <= '0;
      b_reg     <= '0;
      sum_reg   <= '0;
      coeff_reg <= '0;
      prod_reg  <= '0;
      acc_reg   <= '0;
    end else begin
      if (sample_stb) begin
        a0_reg   <= sample_a;
        a1_reg   <= a0_reg;
        b_reg    <= sample_b;
        sum_reg  <= SUM_WIDTH'(a1_reg) + SUM_WIDTH'(b_reg);  // Sign extended pre-add
        prod_reg <= PROD_WIDTH'(sum_reg) * PROD_WIDTH'(coeff_reg);
        acc_reg  <= accum_in + ACCUM_WIDTH'(prod_reg);     // Cascade add
      end
      if (coeff_load) begin
        coeff_reg <= coeff_in;  // Old tap leaves through coeff_fwd
      end
    end
  end

  assign sample_fwd = a1_reg;
  assign coeff_fwd  = coeff_reg;
  assign accum_out  = acc_reg;

endmodule

`default_nettype wire

//--- design/fir_pkg.sv
// Shared types for the symmetric FIR filter
// Vector typedefs at the default widths, Wishbone widths,
// register map and bus FSM states
`default_nettype none

package fir_pkg;

  // Wishbone slave widths
  localparam int WB_ADDR_WIDTH = 4;   // Word address
  localparam int WB_DATA_WIDTH = 32;

  typedef logic signed [15:0] sample_t;  // Input sample, IN_WIDTH default
  typedef logic signed [15:0] coeff_t;   // Tap coefficient, COEFF_WIDTH default
  typedef logic signed [39:0] accum_t;   // Accumulation, ACCUM_WIDTH default
  typedef logic signed [15:0] out_t;     // Filter output, OUT_WIDTH default

  typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
  typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

  // Register map
  typedef enum logic [WB_ADDR_WIDTH-1:0] {
    REG_CTRL   = 4'd0,  // W: bit 0 clears filter and counters
    REG_COEFF  = 4'd1,  // W: push one coefficient into the chain
    REG_NCOEFF = 4'd2,  // R: pushes since last clear
    REG_NSAT   = 4'd3   // R: saturated outputs since last clear
  } reg_addr_e;

  // Bus slave FSM
  typedef enum logic {IDLE, ACK} wb_state_e;

endpackage

`default_nettype wire

//--- design/fir_round_sat.sv
// Output stage of the FIR filter
// Round half up, arithmetic shift, saturate to the output width
// Output strobe and saturation event
`timescale 1ns/1ns
`default_nettype none

module fir_round_sat #(
  parameter int ACCUM_WIDTH = $bits(fir_pkg::accum_t),
  parameter int OUT_WIDTH   = $bits(fir_pkg::out_t),
  parameter int OUT_SHIFT   = 15   // Fraction bits dropped, at least 1
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           clear,
  input  wire                           sample_stb,
  input  wire signed [ACCUM_WIDTH-1:0]  accum_in,
  output logic                          out_stb,   // Two edges after the strobe edge
  output logic signed [OUT_WIDTH-1:0]   out_data,
  output logic                          sat        // Clamped, with out_stb
);

  localparam int RND_WIDTH = ACCUM_WIDTH + 1;  // Room for the rounding carry

  localparam logic signed [RND_WIDTH-1:0] HALF_LSB = RND_WIDTH'(1) << (OUT_SHIFT - 1);
  localparam logic signed [RND_WIDTH-1:0] OUT_MAX =
    {{(RND_WIDTH-OUT_WIDTH+1){1'b0}}, {(OUT_WIDTH-1){1'b1}}};
  localparam logic signed [RND_WIDTH-1:0] OUT_MIN =
    {{(RND_WIDTH-OUT_WIDTH+1){1'b1}}, {(OUT_WIDTH-1){1'b0}}};

  logic                        stb_d;    // Chain result settles one cycle after strobe
  logic signed [RND_WIDTH-1:0] rounded;
  logic signed [RND_WIDTH-1:0] shifted;

  assign rounded = RND_WIDTH'(accum_in) + HALF_LSB;
  assign shifted = rounded >>> OUT_SHIFT;

  always_ff @(posedge clk) begin
    if (rst) begin
      stb_d    <= 1'b0;
      out_stb  <= 1'b0;
      out_data <= '0;
      sat      <= 1'b0;
    end else begin
      stb_d   <= sample_stb;
      out_stb <= stb_d;     // One output per strobe, clear or not
      if (clear) begin
        out_data <= '0;
        sat      <= 1'b0;
      end else if (stb_d) begin
        if (shifted > OUT_MAX) begin
          out_data <= OUT_MAX[OUT_WIDTH-1:0];
          sat      <= 1'b1;
        end else if (shifted < OUT_MIN) begin
          out_data <= OUT_MIN[OUT_WIDTH-1:0];
          sat      <= 1'b1;
        end else begin
          out_data <= shifted[OUT_WIDTH-1:0];
          sat      <= 1'b0;
        end
      end else begin
        sat <= 1'b0;  // Event lasts one cycle
      end
    end
  end

endmodule

`default_nettype wire

//--- design/fir_symmetric_chain.sv
// Systolic chain of pre-add MAC slices for an even-length symmetric FIR
// Entry register, sample and coefficient forwarding, fold-back path
// and accumulation cascade
`timescale 1ns/1ns
`default_nettype none

module fir_symmetric_chain #(
  parameter int IN_WIDTH    = $bits(fir_pkg::sample_t),
  parameter int COEFF_WIDTH = $bits(fir_pkg::coeff_t),
  parameter int ACCUM_WIDTH = $bits(fir_pkg::accum_t),
  parameter int NUM_SLICES  = 4   // Taps = 2 * NUM_SLICES
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           clear,
  input  wire                           sample_stb,
  input  wire signed [IN_WIDTH-1:0]     sample_in,
  input  wire                           coeff_load,  // Shift in coeff_data at slice 0
  input  wire signed [COEFF_WIDTH-1:0]  coeff_data,
  output logic signed [ACCUM_WIDTH-1:0] accum_out
);

  // Latency from strobe n to result in accum_out is NUM_SLICES + 4 strobes:
  // entry register 1, a-path 2 per slice to reach the taps, pre-add,
  // multiply, then one accumulate stage per slice
  //
  // Slice i holds tap h[i] and pairs x[m-i] with x[m-(2*NUM_SLICES-1-i)]

  wire signed [IN_WIDTH-1:0]    sample_link [NUM_SLICES+1];  // a-path between slices
  wire signed [COEFF_WIDTH-1:0] coeff_link  [NUM_SLICES+1];  // Coefficient shift chain
  wire signed [ACCUM_WIDTH-1:0] accum_link  [NUM_SLICES+1];  // Partial sums

  logic signed [IN_WIDTH-1:0] head_reg;     // Entry stage of the delay line
  logic signed [IN_WIDTH-1:0] fold_sample;  // Broadcast to every b-input

  // Entry register, steps with the strobe like every slice stage
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      head_reg <= '0;
    end else if (sample_stb) begin
      head_reg <= sample_in;
    end
  end

  assign sample_link[0] = head_reg;
  assign coeff_link[0]  = coeff_data;
  assign accum_link[0]  = '0;         // Nothing ahead of slice 0

  // Fold-back delay register: the last slice's second a-stage, which
  // holds x[n-2*NUM_SLICES] after strobe n. Each slice captures it into its
  // b-register, so the oldest samples meet their mirrored partners
  // exactly when the accumulation wave passes that slice.
  assign fold_sample = sample_link[NUM_SLICES];

  for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
    fir_mac_slice #(
      .IN_WIDTH   (IN_WIDTH),
      .COEFF_WIDTH(COEFF_WIDTH),
      .ACCUM_WIDTH(ACCUM_WIDTH)
    ) slice_i (
      .clk       (clk),
      .rst       (rst),
      .clear     (clear),
      .sample_stb(sample_stb),
      .sample_a  (sample_link[i]),    // Two strobes deep per slice
      .sample_b  (fold_sample),
      .coeff_in  (coeff_link[i]),
      .coeff_load(coeff_load),        // Whole chain shifts on each push
      .accum_in  (accum_link[i]),
      .sample_fwd(sample_link[i+1]),
      .coeff_fwd (coeff_link[i+1]),   // Last one falls off the end
      .accum_out (accum_link[i+1])
    );
  end

  // Complete sum leaves the last slice
  assign accum_out = accum_link[NUM_SLICES];

endmodule

`default_nettype wire

//--- design/fir_wb_regs.sv
// Wishbone classic register slave for the FIR filter
// Clear command, coefficient pushes, push and saturation counters
`timescale 1ns/1ns
`default_nettype none

module fir_wb_regs #(
  parameter int COEFF_WIDTH = $bits(fir_pkg::coeff_t)
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           wb_cyc,
  input  wire                           wb_stb,
  input  wire                           wb_we,
  input  wire fir_pkg::wb_addr_t        wb_adr,
  input  wire fir_pkg::wb_data_t        wb_dat_w,
  input  wire                           sat,         // One pulse per clamped output
  output fir_pkg::wb_data_t             wb_dat_r,
  output logic                          wb_ack,
  output logic                          coeff_load,  // Push strobe, ack cycle
  output logic signed [COEFF_WIDTH-1:0] coeff_data,
  output logic                          clear        // Clear pulse, ack cycle
);

  import fir_pkg::*;

  wb_state_e state;
  reg_addr_e reg_sel;     // Decoded word address
  wb_data_t  rd_data;     // Read mux
  wb_data_t  ncoeff_cnt;  // Pushes since clear
  wb_data_t  nsat_cnt;    // Saturations since clear
  logic      wr_ack;      // Write completing this cycle

  assign reg_sel = reg_addr_e'(wb_adr);

  // Master holds its request until ack, so decode in the ack cycle
  assign wb_ack     = (state == ACK);
  assign wr_ack     = wb_ack && wb_cyc && wb_stb && wb_we;
  assign coeff_load = wr_ack && (reg_sel == REG_COEFF);
  assign coeff_data = wb_dat_w[COEFF_WIDTH-1:0];  // Low bits only
  assign clear      = wr_ack && (reg_sel == REG_CTRL) && wb_dat_w[0];

  always_comb begin
    case (reg_sel)
      REG_NCOEFF: rd_data = ncoeff_cnt;
      REG_NSAT:   rd_data = nsat_cnt;
      default:    rd_data = '0;  // Write-only and unmapped words
    endcase
  end

  // Two-state slave, one ack per request, back to IDLE after each
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      wb_dat_r <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (wb_cyc && wb_stb) begin
            state    <= ACK;
            wb_dat_r <= wb_we ? '0 : rd_data;  // Valid with ack
          end
        end
        ACK: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Status counters
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      ncoeff_cnt <= '0;
      nsat_cnt   <= '0;
    end else begin
      if (coeff_load) begin
        ncoeff_cnt <= ncoeff_cnt + 1'b1;
      end
      if (sat) begin
        nsat_cnt <= nsat_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/fir_filter_tb.sv
// Testbench for the symmetric FIR filter top level
// Wishbone access tasks, file driven stimulus, impulse and random streams
// Output monitor, per-test reporting and watchdog
`timescale 1ns/1ns
`default_nettype none

module fir_filter_tb;

  localparam int N = 4;              // Tap pairs
  localparam int D = N + 4;          // Chain latency in strobes
  localparam int A_CTRL = 0;
  localparam int A_COEFF = 1;
  localparam int A_NCOEFF = 2;
  localparam int A_NSAT = 3;
  localparam int O_MAX = 32767;
  localparam int O_MIN = -32768;

  logic clk = 1'b0;
  logic rst;
  logic wb_cyc, wb_stb, wb_we;
  logic [3:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic wb_ack;
  logic sample_stb;
  logic signed [15:0] sample_in;
  logic out_stb;
  logic signed [15:0] out_data;

  int err_cnt = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int strobes = 0;     // Issued so far for the watchdog
  int bus_ops = 0;
  int limit_hits = 0;  // Outputs sitting at a clamp limit
  int test_err0 = 0;
  bit test_open = 0;
  string test_name;
  logic [1:0] stb_hist = '0;  // sample_stb seen at the last two edges
  int exp_val[$];             // Expected value per issued strobe
  bit exp_chk[$];
  int pend_val[$];            // Rule outputs waiting for latency D
  bit pend_chk[$];
  int w[N];                   // Coefficients in write order
  longint taps[2*N];
  int row_gap[32], row_x[32], row_y[32];
  int n_rows = 0;
  int ev;
  bit ec;

  fir_filter_top dut_i (
    .clk(clk), .rst(rst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
    .sample_stb(sample_stb), .sample_in(sample_in),
    .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .out_stb(out_stb), .out_data(out_data)
  );

  always #50 clk = ~clk;  // 100 ns period

  always @(posedge clk) stb_hist <= {stb_hist[0], sample_stb};

  // Output monitor samples mid cycle when everything is stable
  always @(negedge clk) begin
    if (!rst) begin
      if (out_stb !== stb_hist[1]) begin
        $display("Error at %0t: out_stb %b but sample_stb two cycles back was %b",
                 $time, out_stb, stb_hist[1]);
        err_cnt++;
      end
      if (out_stb) begin
        if (out_data == O_MAX || out_data == O_MIN) limit_hits++;
        if (exp_val.size() == 0) begin
          $display("Output strobe at %0t with no sample waiting for it", $time);
          err_cnt++;
        end else begin
          ev = exp_val.pop_front();
          ec = exp_chk.pop_front();
          if (ec && int'(out_data) != ev) begin
            $display("Error at %0t: out_data %0d, expected %0d", $time, out_data, ev);
            err_cnt++;
          end
        end
      end
    end
  end

  // Limit grows with the work issued so a stalled handshake runs into it
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= strobes * 4 + bus_ops * 4 + 200) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: DUT stalled after %0d cycles in test %s", cycles, test_name);
    $display("STATUS: FAIL");
    $finish;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  // Half LSB, arithmetic shift by 15, clamp to 16 bits
  function automatic int rule_out(input longint acc);
    longint r;
    r = (acc + 64'sd16384) >>> 15;
    if (r > O_MAX) return O_MAX;
    if (r < O_MIN) return O_MIN;
    return int'(r);
  endfunction

  task automatic begin_test(input string name);
    if (test_open) begin
      if (err_cnt == test_err0) begin
        pass_cnt++;
        $display("Test %s finished, no errors", test_name);
      end else begin
        fail_cnt++;
        $display("Test %s finished, %0d errors", test_name, err_cnt - test_err0);
      end
    end
    test_open = (name != "");
    test_name = name;
    test_err0 = err_cnt;
  endtask

  task automatic bus_access(input logic we, input int adr, input int wdat,
                            output logic [31:0] rdat);
    int waited;
    waited = 0;
    bus_ops++;
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= we;
    wb_adr <= adr[3:0];
    wb_dat_w <= wdat;
    @(negedge clk);
    while (!wb_ack && waited < 16) begin
      @(negedge clk);
      waited++;
    end
    if (!wb_ack) begin
      $display("Bus access to address %0d got no ack", adr);
      err_cnt++;
    end
    rdat = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
    @(negedge clk);
    if (wb_ack) begin
      $display("Error at %0t: ack still high a cycle after the access", $time);
      err_cnt++;
    end
  endtask

  task automatic bus_write(input int adr, input int wdat);
    logic [31:0] unused;
    bus_access(1'b1, adr, wdat, unused);
  endtask

  task automatic read_expect(input int adr, input int expected);
    logic [31:0] rdat;
    bus_access(1'b0, adr, 0, rdat);
    if (rdat != expected) begin
      $display("Error at %0t: register %0d read %0d, expected %0d", $time, adr, rdat, expected);
      err_cnt++;
    end
  endtask

  task automatic reset_pending();
    pend_val.delete();
    pend_chk.delete();
    repeat (D) begin
      pend_val.push_back(0);  // Cleared chain gives zeros first
      pend_chk.push_back(1'b1);
    end
  endtask

  // One strobe; y is the rule output for this input index
  task automatic send_sample(input int gap, input int x, input int y, input bit chk);
    pend_val.push_back(y);
    pend_chk.push_back(chk);
    repeat (gap) @(posedge clk);
    @(posedge clk);
    sample_stb <= 1'b1;
    sample_in <= x[15:0];
    exp_val.push_back(pend_val.pop_front());
    exp_chk.push_back(pend_chk.pop_front());
    strobes++;
    @(posedge clk);
    sample_stb <= 1'b0;
  endtask

  task automatic flush_chain();
    for (int i = 0; i < 3 * D; i++) send_sample(0, 0, 0, 1'b0);  // Tail unchecked
    repeat (4) @(posedge clk);
    if (exp_val.size() != 0) begin
      $display("%0d expected outputs never appeared", exp_val.size());
      err_cnt++;
    end
    reset_pending();
  endtask

  task automatic load_coeffs(input bit do_clear);
    if (do_clear) begin
      bus_write(A_CTRL, 1);
      read_expect(A_NCOEFF, 0);
    end
    for (int i = 0; i < N; i++) bus_write(A_COEFF, w[i]);
    read_expect(A_NCOEFF, N);
    for (int j = 0; j < N; j++) begin
      taps[j] = w[N-1-j];          // Last written sits in slice 0
      taps[2*N-1-j] = w[N-1-j];    // Mirror half
    end
    reset_pending();
  endtask

  initial begin : main
    int fd, r, gap, x, y, n;
    bit done, rows_open, first_coeff;
    logic [127:0] tok;
    logic [2047:0] line;
    logic [15:0] lfsr, smp;
    logic [31:0] nsat;
    done = 0;
    rows_open = 0;
    first_coeff = 1;
    rst <= 1'b1;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
    wb_adr <= '0;
    wb_dat_w <= '0;
    sample_stb <= 1'b0;
    sample_in <= '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    begin_test("bus_readback");
    read_expect(A_NCOEFF, 0);
    read_expect(A_NSAT, 0);
    read_expect(7, 0);  // Unmapped word
    fd = $fopen("testbench/fir_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      err_cnt++;
      done = 1;
    end
    while (!done) begin
      r = $fscanf(fd, "%s", tok);
      if (r != 1) begin
        $display("Stimulus file ended before its end line");
        err_cnt++;
        done = 1;
      end else if (tok == "#") begin
        r = $fgets(line, fd);
      end else if (tok == "s") begin
        r = $fscanf(fd, "%d %d %d", gap, x, y);
        row_gap[n_rows] = gap;
        row_x[n_rows] = x;
        row_y[n_rows] = y;
        n_rows++;
        send_sample(gap, x, y, 1'b1);
        rows_open = 1;
      end else begin
        if (rows_open) flush_chain();
        rows_open = 0;
        if (tok == "coeff") begin
          r = $fscanf(fd, "%d %d %d %d", w[0], w[1], w[2], w[3]);
          n_rows = 0;
          if (first_coeff) begin
            begin_test("coeff_load");
            load_coeffs(1'b1);
            for (int k = 0; k < 2 * N; k++) begin  // Impulse shows taps in order
              send_sample(0, (k == 0) ? O_MAX : 0, rule_out(taps[k] * O_MAX), 1'b1);
            end
            flush_chain();
            begin_test("filter");
            first_coeff = 0;
          end else begin
            begin_test("saturation");
            load_coeffs(1'b1);
          end
        end else if (tok == "clear") begin
          begin_test("clear");
          for (int k = 0; k < 2 * N; k++) begin  // Full scale with tap signs clamps at the peak
            send_sample(0, (taps[2*N-1-k] < 0) ? O_MIN : O_MAX, 0, 1'b0);
          end
          for (int k = 0; k < D; k++) send_sample(0, 0, 0, 1'b0);  // Peak reaches out_data
          repeat (3) @(posedge clk);
          bus_access(1'b0, A_NSAT, 0, nsat);
          if (nsat == 0) begin
            $display("Error at %0t: REG_NSAT 0 after a clamping stream", $time);
            err_cnt++;
          end
          bus_write(A_CTRL, 1);
          if (out_data != 0) begin
            $display("Error at %0t: out_data %0d after clear, expected 0", $time, out_data);
            err_cnt++;
          end
          read_expect(A_NCOEFF, 0);
          read_expect(A_NSAT, 0);
          load_coeffs(1'b0);  // No second clear as the chain is already empty
          for (int k = 0; k < n_rows; k++) send_sample(row_gap[k], row_x[k], row_y[k], 1'b1);
          flush_chain();
        end else if (tok == "nsat") begin
          r = $fscanf(fd, "%d", n);
          read_expect(A_NSAT, n);
        end else if (tok == "end") begin
          done = 1;
        end else begin
          $display("Unknown keyword in stimulus file");
          err_cnt++;
          done = 1;
        end
      end
    end
    if (fd != 0) $fclose(fd);
    // Random stream with the last taps and only counter bounds known
    begin_test("random");
    load_coeffs(1'b1);
    limit_hits = 0;
    lfsr = 16'd19;
    for (int k = 0; k < 64; k++) begin
      for (int b = 0; b < 16; b++) begin
        smp[b] = lfsr[15];
        lfsr = lfsr_next(lfsr);
      end
      send_sample(0, int'($signed(smp)), 0, 1'b0);
    end
    flush_chain();
    bus_access(1'b0, A_NSAT, 0, nsat);
    if (nsat > limit_hits) begin
      $display("Error at %0t: REG_NSAT %0d, only %0d outputs at a limit", $time, nsat, limit_hits);
      err_cnt++;
    end
    begin_test("");
    $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/fir_stim.txt
# coeff w0 w1 w2 w3 : clear, then push taps in write order ; s gap x y : idle cycles, sample, y[k]
# clear : clear in mid stream, reload, replay rows ; nsat n : expected REG_NSAT ; end
coeff -8192 0 8192 16384
s 0 100 50
s 2 -40 5
s 1 7 -6
s 0 0 -23
s 3 250 110
s 0 -3 69
s 1 0 23
s 0 0 -22
s 2 0 -80
s 0 0 4
s 1 0 63
s 0 0 124
s 0 0 -1
clear
coeff 32767 32767 32767 32767
s 0 32767 32766
s 1 32767 32767
s 0 -32768 32765
s 2 -32768 -2
s 0 0 -2
s 0 0 -2
s 1 0 -2
s 0 0 -2
s 0 0 -32768
s 0 0 -32768
s 0 0 -32767
nsat 2
end

//--- vlog.f
design/fir_pkg.sv
design/fir_mac_slice.sv
design/fir_symmetric_chain.sv
design/fir_wb_regs.sv
design/fir_round_sat.sv
design/fir_filter_top.sv
testbench/fir_filter_tb.sv
